//--- all.f
rtl/lcd_pkg.sv
rtl/scan_if.sv
rtl/scan_timer.sv
rtl/tile_locator.sv
rtl/pixel_shader.sv
rtl/backlight_dimmer.sv
rtl/lcd_panel_top.sv
tb/lcd_panel_chk.sv
tb/lcd_panel_tb.sv

//--- Bender.yml
package:
  name: lcd_panel

sources:
  - rtl/lcd_pkg.sv
  - rtl/scan_if.sv
  - rtl/scan_timer.sv
  - rtl/tile_locator.sv
  - rtl/pixel_shader.sv
  - rtl/backlight_dimmer.sv
  - rtl/lcd_panel_top.sv
  - target: test
    files:
      - tb/lcd_panel_chk.sv
      - tb/lcd_panel_tb.sv

//--- tb/lcd_panel_tb.sv
module lcd_panel_tb;

	logic                    clk_33MHz_i;
	logic                    rst_n_i;
	logic [lcd_pkg::BPP-1:0] lcd_r;
	logic [lcd_pkg::BPP-1:0] lcd_g;
	logic [lcd_pkg::BPP-1:0] lcd_b;
	logic                    lcd_de;
	logic                    lcd_pwm;

	// Edges since the last reset release
	int          edge_cnt;
	int          win_high;
	int          target;
	logic [31:0] rng;

	initial clk_33MHz_i = 1'b0;
	always #10 clk_33MHz_i = ~clk_33MHz_i;

	lcd_panel_top i_lcd_panel_top (
		.clk_33MHz_i (clk_33MHz_i),
		.rst_n_i     (rst_n_i),
		.lcd_r_o     (lcd_r),
		.lcd_g_o     (lcd_g),
		.lcd_b_o     (lcd_b),
		.lcd_de_o    (lcd_de),
		.lcd_pwm_o   (lcd_pwm)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Output after edge e shows the raster position of edge e-2
	function automatic logic de_at(input int e);
		int p;
		int h;
		int v;
		if (e < 2) begin
			return 1'b0;
		end
		p = (e - 2) % (lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL);
		h = p % lcd_pkg::H_TOTAL;
		v = p / lcd_pkg::H_TOTAL;
		return (h >= lcd_pkg::H_BLANK) && (v >= lcd_pkg::V_BLANK);
	endfunction

	// 0 red, 1 blue, 2 green
	function automatic int color_at(input int e);
		int p;
		int k;
		int j;
		if (e < 2) begin
			return 0;
		end
		p = (e - 2) % (lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL);
		k = p % lcd_pkg::H_TOTAL - lcd_pkg::H_BLANK;
		j = p / lcd_pkg::H_TOTAL - lcd_pkg::V_BLANK;
		return ((k / lcd_pkg::TILE_SIZE) - (j / lcd_pkg::TILE_SIZE) + 3) % 3;
	endfunction

	// Ramp of 101 steps up, one held top, 100 down, one held bottom
	function automatic int threshold_for_window(input int n);
		int m;
		m = n % 202;
		if (m <= 100) begin
			return m * lcd_pkg::PWM_STEP;
		end else if (m == 101) begin
			return lcd_pkg::PWM_PERIOD;
		end else begin
			return (201 - m) * lcd_pkg::PWM_STEP;
		end
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input int expected, input int actual);
		assert (expected == actual) else
			abort_run($sformatf("mismatch %s: expected %0h, actual %0h", test, expected, actual));
	endtask

	task automatic check_bound_assertions();
		assert (i_lcd_panel_top.i_lcd_panel_chk.fail_cnt == 0) else
			abort_run("a bound assertion on the panel outputs failed");
	endtask

	task automatic check_outputs();
		logic exp_de;
		int   idx;
		exp_de = de_at(edge_cnt);
		idx    = color_at(edge_cnt);
		assert (!$isunknown({lcd_r, lcd_g, lcd_b, lcd_de, lcd_pwm})) else
			abort_run($sformatf("unknown value on a DUT output at edge %0d", edge_cnt));
		check_value("de_timing", exp_de, lcd_de);
		check_value("red_channel", (exp_de && idx == 0) ? lcd_pkg::COLOR_ON : 0, lcd_r);
		check_value("blue_channel", (exp_de && idx == 1) ? lcd_pkg::COLOR_ON : 0, lcd_b);
		check_value("green_channel", (exp_de && idx == 2) ? lcd_pkg::COLOR_ON : 0, lcd_g);
		if (lcd_pwm) begin
			win_high++;
		end
		// Window n ends on edge (n+1) x PWM_PERIOD
		if (edge_cnt % lcd_pkg::PWM_PERIOD == 0) begin
			check_value("pwm_duty", threshold_for_window(edge_cnt / lcd_pkg::PWM_PERIOD - 1),
				win_high);
			win_high = 0;
		end
	endtask

	task automatic step_cycle();
		@(posedge clk_33MHz_i);
		#1;
		edge_cnt++;
		check_outputs();
		check_bound_assertions();
	endtask

	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			step_cycle();
		end
	endtask

	task automatic hold_reset(input int cycles);
		rst_n_i = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_33MHz_i);
			#1;
			check_value("reset_outputs", 0, {lcd_r, lcd_g, lcd_b, lcd_de, lcd_pwm});
			check_bound_assertions();
		end
		rst_n_i  = 1'b1;
		edge_cnt = 0;
		win_high = 0;
	endtask

	task automatic wait_first_de();
		int limit;
		limit = lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL;
		while (lcd_de !== 1'b1 && edge_cnt < limit) begin
			step_cycle();
		end
		assert (lcd_de === 1'b1) else
			abort_run("lcd_de_o never rose within one frame after reset release");
		check_value("first_de_rise",
			lcd_pkg::V_BLANK * lcd_pkg::H_TOTAL + lcd_pkg::H_BLANK + 2, edge_cnt);
	endtask

	initial begin
		edge_cnt = 0;
		win_high = 0;
		rng      = 32'h6307f8db;
		hold_reset(8);

		// Runs of 1 to 1.5 frames cut short by a random reset pulse
		for (int run = 0; run < 3; run++) begin
			wait_first_de();
			rng    = xorshift32(rng);
			target = lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL +
				int'(rng % (lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL / 2));
			run_cycles(target - edge_cnt);
			rng = xorshift32(rng);
			hold_reset(1 + int'(rng % 8));
		end

		// Two frames plus a whole breathing cycle
		wait_first_de();
		target = 2 * lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL + 203 * lcd_pkg::PWM_PERIOD;
		run_cycles(target - edge_cnt);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tb/lcd_panel_chk.sv
module lcd_panel_chk (
	input logic                    clk_33MHz_i,
	input logic                    rst_n_i,
	input logic [lcd_pkg::BPP-1:0] lcd_r_i,
	input logic [lcd_pkg::BPP-1:0] lcd_g_i,
	input logic [lcd_pkg::BPP-1:0] lcd_b_i,
	input logic                    lcd_de_i
);

	// Failure count polled by the testbench
	int fail_cnt = 0;

	// Black outside the active area
	assert property (@(posedge clk_33MHz_i) disable iff (!rst_n_i)
		!lcd_de_i |-> (lcd_r_i == '0 && lcd_g_i == '0 && lcd_b_i == '0))
		else begin
			$error("colour output while data enable is low");
			fail_cnt++;
		end

	// Pure primaries only
	assert property (@(posedge clk_33MHz_i) disable iff (!rst_n_i)
		$onehot0({|lcd_r_i, |lcd_g_i, |lcd_b_i}))
		else begin
			$error("more than one colour channel active");
			fail_cnt++;
		end

	assert property (@(posedge clk_33MHz_i) disable iff (!rst_n_i)
		(lcd_r_i == '0 || lcd_r_i == lcd_pkg::COLOR_ON) &&
		(lcd_g_i == '0 || lcd_g_i == lcd_pkg::COLOR_ON) &&
		(lcd_b_i == '0 || lcd_b_i == lcd_pkg::COLOR_ON))
		else begin
			$error("colour channel at a partial level");
			fail_cnt++;
		end

	assert property (@(posedge clk_33MHz_i) !rst_n_i |-> !lcd_de_i)
		else begin
			$error("data enable high during reset");
			fail_cnt++;
		end

endmodule

bind lcd_panel_top lcd_panel_chk i_lcd_panel_chk (
	.clk_33MHz_i (clk_33MHz_i),
	.rst_n_i     (rst_n_i),
	.lcd_r_i     (lcd_r_o),
	.lcd_g_i     (lcd_g_o),
	.lcd_b_i     (lcd_b_o),
	.lcd_de_i    (lcd_de_o)
);

//--- rtl/lcd_panel_top.sv
module lcd_panel_top (
	input  logic                    clk_33MHz_i,
	input  logic                    rst_n_i,
	output logic [lcd_pkg::BPP-1:0] lcd_r_o,
	output logic [lcd_pkg::BPP-1:0] lcd_g_o,
	output logic [lcd_pkg::BPP-1:0] lcd_b_o,
	output logic                    lcd_de_o,
	output logic                    lcd_pwm_o
);

	lcd_pkg::tile_color_e tile_color;
	logic                 pix_active;

	scan_if scan ();

	// Video path: raster timer, tile locator, shader
	scan_timer i_scan_timer (
		.clk_33MHz_i (clk_33MHz_i),
		.rst_n_i     (rst_n_i),
		.scan        (scan.timer)
	);

	tile_locator i_tile_locator (
		.clk_33MHz_i  (clk_33MHz_i),
		.rst_n_i      (rst_n_i),
		.scan         (scan.locator),
		.tile_color_o (tile_color),
		.pix_active_o (pix_active)
	);

	pixel_shader i_pixel_shader (
		.clk_33MHz_i  (clk_33MHz_i),
		.rst_n_i      (rst_n_i),
		.tile_color_i (tile_color),
		.pix_active_i (pix_active),
		.lcd_r_o      (lcd_r_o),
		.lcd_g_o      (lcd_g_o),
		.lcd_b_o      (lcd_b_o),
		.lcd_de_o     (lcd_de_o)
	);

	// Backlight runs on its own beside the video path
	backlight_dimmer i_backlight_dimmer (
		.clk_33MHz_i (clk_33MHz_i),
		.rst_n_i     (rst_n_i),
		.lcd_pwm_o   (lcd_pwm_o)
	);

endmodule

//--- rtl/backlight_dimmer.sv
module backlight_dimmer (
	input  logic clk_33MHz_i,
	input  logic rst_n_i,
	output logic lcd_pwm_o
);

	logic [lcd_pkg::PWM_W-1:0] pwm_cnt;
	logic [lcd_pkg::PWM_W-1:0] threshold;
	logic                      pwm_wrap;
	lcd_pkg::pwm_dir_e         dir;

	assign pwm_wrap = (pwm_cnt == lcd_pkg::PWM_PERIOD - 1);

	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pwm_cnt <= '0;
		end else if (pwm_wrap) begin
			pwm_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// Threshold moves once per period; a turn-around holds it one more period
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dir       <= lcd_pkg::PWM_RISE;
			threshold <= '0;
		end else if (pwm_wrap) begin
			case (dir)
				lcd_pkg::PWM_RISE: begin
					if (threshold >= lcd_pkg::PWM_PERIOD) begin
						dir <= lcd_pkg::PWM_FALL;
					end else begin
						threshold <= threshold + lcd_pkg::PWM_STEP;
					end
				end
				default: begin
					if (threshold == '0) begin
						dir <= lcd_pkg::PWM_RISE;
					end else begin
						threshold <= threshold - lcd_pkg::PWM_STEP;
					end
				end
			endcase
		end
	end

	// High for the first threshold counts of each period
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lcd_pwm_o <= 1'b0;
		end else begin
			lcd_pwm_o <= (pwm_cnt < threshold);
		end
	end

endmodule

//--- rtl/pixel_shader.sv
module pixel_shader (
	input  logic                      clk_33MHz_i,
	input  logic                      rst_n_i,
	input  lcd_pkg::tile_color_e      tile_color_i,
	input  logic                      pix_active_i,
	output logic [lcd_pkg::BPP-1:0]   lcd_r_o,
	output logic [lcd_pkg::BPP-1:0]   lcd_g_o,
	output logic [lcd_pkg::BPP-1:0]   lcd_b_o,
	output logic                      lcd_de_o
);

	logic [lcd_pkg::BPP-1:0] r_nxt;
	logic [lcd_pkg::BPP-1:0] g_nxt;
	logic [lcd_pkg::BPP-1:0] b_nxt;

	// Pure primaries only, black outside the active area
	always_comb begin
		r_nxt = lcd_pkg::COLOR_OFF;
		g_nxt = lcd_pkg::COLOR_OFF;
		b_nxt = lcd_pkg::COLOR_OFF;
		if (pix_active_i) begin
			case (tile_color_i)
				lcd_pkg::RED:   r_nxt = lcd_pkg::COLOR_ON;
				lcd_pkg::BLUE:  b_nxt = lcd_pkg::COLOR_ON;
				lcd_pkg::GREEN: g_nxt = lcd_pkg::COLOR_ON;
				default:        r_nxt = lcd_pkg::COLOR_OFF;
			endcase
		end
	end

	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lcd_r_o  <= lcd_pkg::COLOR_OFF;
			lcd_g_o  <= lcd_pkg::COLOR_OFF;
			lcd_b_o  <= lcd_pkg::COLOR_OFF;
			lcd_de_o <= 1'b0;
		end else begin
			lcd_r_o  <= r_nxt;
			lcd_g_o  <= g_nxt;
			lcd_b_o  <= b_nxt;
			lcd_de_o <= pix_active_i;
		end
	end

endmodule

//--- rtl/tile_locator.sv
module tile_locator (
	input  logic                 clk_33MHz_i,
	input  logic                 rst_n_i,
	scan_if.locator              scan,
	output lcd_pkg::tile_color_e tile_color_o,
	output logic                 pix_active_o
);

	logic [lcd_pkg::TILE_CNT_W-1:0] pix_cnt;
	logic [lcd_pkg::TILE_CNT_W-1:0] line_cnt;
	logic                           pix_last;
	logic                           line_last;
	lcd_pkg::tile_color_e           cur_color;
	lcd_pkg::tile_color_e           row_color;
	lcd_pkg::tile_color_e           row_next;

	// One tile to the right
	function automatic lcd_pkg::tile_color_e color_inc(input lcd_pkg::tile_color_e c);
		case (c)
			lcd_pkg::RED:  color_inc = lcd_pkg::BLUE;
			lcd_pkg::BLUE: color_inc = lcd_pkg::GREEN;
			default:       color_inc = lcd_pkg::RED;
		endcase
	endfunction

	// One tile down
	function automatic lcd_pkg::tile_color_e color_dec(input lcd_pkg::tile_color_e c);
		case (c)
			lcd_pkg::RED:   color_dec = lcd_pkg::GREEN;
			lcd_pkg::GREEN: color_dec = lcd_pkg::BLUE;
			default:        color_dec = lcd_pkg::RED;
		endcase
	endfunction

	assign pix_last  = (pix_cnt == lcd_pkg::TILE_SIZE - 1);
	assign line_last = (line_cnt == lcd_pkg::TILE_SIZE - 1);

	// Colour of tile column 0 on the line that starts next
	always_comb begin
		row_next = row_color;
		if (scan.frame_end) begin
			row_next = lcd_pkg::RED;
		end else if (scan.line_end && scan.v_active && line_last) begin
			row_next = color_dec(row_color);
		end
	end

	// Lines inside the current tile row
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			line_cnt  <= '0;
			row_color <= lcd_pkg::RED;
		end else begin
			row_color <= row_next;
			if (scan.frame_end) begin
				line_cnt <= '0;
			end else if (scan.line_end && scan.v_active) begin
				line_cnt <= line_last ? '0 : line_cnt + 1'b1;
			end
		end
	end

	// Pixels inside the current tile, cur_color is valid for the present count
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pix_cnt   <= '0;
			cur_color <= lcd_pkg::RED;
		end else if (scan.line_end) begin
			pix_cnt   <= '0;
			cur_color <= row_next;
		end else if (scan.h_active) begin
			if (pix_last) begin
				pix_cnt   <= '0;
				cur_color <= color_inc(cur_color);
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tile_color_o <= lcd_pkg::RED;
			pix_active_o <= 1'b0;
		end else begin
			tile_color_o <= cur_color;
			pix_active_o <= scan.h_active && scan.v_active;
		end
	end

endmodule

//--- rtl/scan_timer.sv
module scan_timer (
	input logic   clk_33MHz_i,
	input logic   rst_n_i,
	scan_if.timer scan
);

	logic [lcd_pkg::H_CNT_W-1:0] h_cnt;
	logic [lcd_pkg::V_CNT_W-1:0] v_cnt;
	logic                        h_last;
	logic                        v_last;

	assign h_last = (h_cnt == lcd_pkg::H_TOTAL - 1);
	assign v_last = (v_cnt == lcd_pkg::V_TOTAL - 1);

	// Pixel position on the line
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			h_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Line number, steps once per horizontal wrap
	always_ff @(posedge clk_33MHz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			v_cnt <= '0;
		end else if (h_last) begin
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	// Blanking comes first, so active is simply at or past the blank width
	assign scan.h_active  = (h_cnt >= lcd_pkg::H_BLANK);
	assign scan.v_active  = (v_cnt >= lcd_pkg::V_BLANK);
	assign scan.line_end  = h_last;
	assign scan.frame_end = h_last && v_last;

endmodule

//--- rtl/scan_if.sv
interface scan_if;

	// Levels, high inside the active part of the line or frame
	logic h_active;
	logic v_active;
	// Single-cycle strobes on the last count
	logic line_end;
	logic frame_end;

	modport timer (
		output h_active,
		output v_active,
		output line_end,
		output frame_end
	);

	modport locator (
		input h_active,
		input v_active,
		input line_end,
		input frame_end
	);

endinterface

//--- rtl/lcd_pkg.sv
package lcd_pkg;

	// Raster of the 800x480 panel, blanking first on every line and frame
	localparam int H_ACTIVE = 800;
	localparam int H_BLANK  = 256;
	localparam int H_TOTAL  = H_BLANK + H_ACTIVE;
	localparam int V_ACTIVE = 480;
	localparam int V_BLANK  = 45;
	localparam int V_TOTAL  = V_BLANK + V_ACTIVE;
	localparam int H_CNT_W  = $clog2(H_TOTAL);
	localparam int V_CNT_W  = $clog2(V_TOTAL);

	// Test card grid
	localparam int TILE_COLS  = 5;
	localparam int TILE_ROWS  = 3;
	localparam int TILE_SIZE  = H_ACTIVE / TILE_COLS;
	localparam int TILE_CNT_W = $clog2(TILE_SIZE);

	localparam int BPP = 8;
	localparam logic [BPP-1:0] COLOR_ON  = '1;
	localparam logic [BPP-1:0] COLOR_OFF = '0;

	// Order follows (col - row) mod 3
	typedef enum logic [1:0] {
		RED,
		BLUE,
		GREEN
	} tile_color_e;

	// Backlight breathing
	localparam int PWM_PERIOD = 1000;
	localparam int PWM_W      = $clog2(PWM_PERIOD + 1);
	localparam logic [PWM_W-1:0] PWM_STEP = 10;

	typedef enum logic {
		PWM_RISE,
		PWM_FALL
	} pwm_dir_e;

endpackage
